//--- cpu_core_top.f
design/cpu_pkg.sv
design/cpu_controller.sv
design/cpu_alu.sv
design/cpu_register_file.sv
design/cpu_fetch_unit.sv
design/cpu_load_store_unit.sv
design/cpu_bus_arbiter.sv
design/cpu_core_top.sv
verification/tb_clock_gen.sv
verification/cpu_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := cpu_core_tb
FILE_LIST := cpu_core_top.f
BUILD_DIR := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS := --binary --timing --assert -Mdir $(BUILD_DIR)
PASS_MESSAGE := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/cpu_core_patterns.txt
// program words at @000, initial data as address value pairs at @100,
// expected stores as address data pairs at @200 and load checks as
// data address, increment, store address at @300
@000
// movi r1 r2, addi r3, then add sub and or xor into r4..r8
44101234
44207ffd
50308100
40408800
40508c01
40628c02
40721404
40808c03
// store r4..r8 to words 800..804
14400800
14500801
14600802
14700803
14800804
// srli slli rotri ori xori into r9..r13, stored to 805..809
40911009
40a0a008
40b0900b
58c0cf00
56d17000
14900805
14a00806
14b00807
14c00808
14d00809
// load, addi, store back
04e00900
50f70011
14f0080a
05000901
51180001
1510080b
@100
00000900 0badf00d
00000901 7fffffff
@200
00000800 00001231
00000801 ffffff00
00000802 00001300
00000803 ffffff31
00000804 00000100
00000805 0fffffff
00000806 00123400
00000807 40000123
00000808 00005f34
00000809 ffff8ffd
0000080a 0badf01e
0000080b 80000000
@300
00000900 00000011 0000080a
00000901 00000001 0000080b

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int addr_width = 12;
	localparam int mem_words = 1 << addr_width;
	localparam int pattern_words = 1024;
	localparam int timeout_cycles = 5000;
	// sections of the patterns file
	localparam int data_base = 'h100;
	localparam int store_base = 'h200;
	localparam int load_base = 'h300;

	logic clock;
	logic reset;
	logic mem_req_ready;
	logic mem_rsp_valid;
	mem_rsp_t mem_rsp;
	logic mem_req_valid;
	mem_req_t mem_req;

	word_t mem [mem_words];
	word_t patterns [pattern_words];
	int store_index;
	int store_count;
	int wait_cycles;
	logic first_seen;
	logic held_valid;
	mem_req_t held_req;
	word_t read_word;

	tb_clock_gen #(.period(40)) tb_clock_gen_inst (.clock(clock));

	cpu_core_top #(.addr_width(addr_width)) cpu_core_top_inst (
		.clock(clock), .reset(reset), .mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req)
	);

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_req(input string name, input mem_req_t actual, input mem_req_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s addr/write/data %h/%b/%h, expected %h/%b/%h",
				$time, name, actual.addr, actual.write, actual.wdata,
				expected.addr, expected.write, expected.wdata);
			abort_run();
		end
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// background for words the patterns leave out
	function automatic word_t fill_word(input int addr);
		return (word_t'(addr) * 32'h0001_0003) ^ 32'ha5a5_0000;
	endfunction

	function automatic word_t initial_word(input int addr);
		word_t value;
		value = fill_word(addr);
		for (int i = data_base; i < store_base && patterns[i] != '1; i += 2) begin
			if (int'(patterns[i][addr_width-1:0]) == addr) begin
				value = patterns[i + 1];
			end
		end
		return value;
	endfunction

	task automatic read_patterns();
		for (int i = 0; i < pattern_words; i++) begin
			patterns[i] = '1;
		end
		$readmemh("verification/cpu_core_patterns.txt", patterns);
		store_count = 0;
		for (int i = store_base; i < load_base && patterns[i] != '1; i += 2) begin
			store_count++;
		end
		if (store_count == 0) begin
			$display("the patterns file holds no expected stores");
			abort_run();
		end
	endtask

	task automatic init_memory();
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = fill_word(i);
		end
		for (int i = 0; i < data_base && patterns[i] != '1; i++) begin
			mem[i] = patterns[i];
		end
		for (int i = data_base; i < store_base && patterns[i] != '1; i += 2) begin
			mem[patterns[i][addr_width-1:0]] = patterns[i + 1];
		end
	endtask

	// a stored loaded word must equal the initial data plus the addi increment
	task automatic check_load_derived(input logic [addr_width-1:0] store_addr,
		input word_t wdata);
		word_t expected;
		int data_addr;
		for (int i = load_base; i < pattern_words && patterns[i] != '1; i += 3) begin
			if (patterns[i + 2][addr_width-1:0] == store_addr) begin
				data_addr = int'(patterns[i][addr_width-1:0]);
				expected = initial_word(data_addr) + patterns[i + 1];
				check_word($sformatf("load-derived mem_req.wdata to %h", store_addr),
					wdata, expected);
			end
		end
	endtask

	task automatic serve_request(input mem_req_t req);
		mem_req_t expected;
		logic [addr_width-1:0] addr;
		addr = req.addr[addr_width-1:0];
		// program starts at word 0
		if (!first_seen) begin
			first_seen = 1'b1;
			check_req("first mem_req", req, '0);
		end
		if (req.write) begin
			if (store_index >= store_count) begin
				$display("unexpected store to word %h after the last expected store", addr);
				abort_run();
			end
			check_load_derived(addr, req.wdata);
			expected.addr = 30'(patterns[store_base + 2 * store_index]);
			expected.write = 1'b1;
			expected.wdata = patterns[store_base + 2 * store_index + 1];
			check_req($sformatf("store %0d mem_req", store_index), req, expected);
			mem[addr] = req.wdata;
			store_index++;
		end
		read_word = mem[addr];
	endtask

	// memory model with random ready and 1 to 3 cycles of latency
	always @(posedge clock) begin
		mem_rsp_valid <= 1'b0;
		if (reset) begin
			if (mem_req_valid) begin
				$display("mem_req_valid high at %0t while reset is asserted", $time);
				abort_run();
			end
			mem_req_ready <= 1'b0;
			init_memory();
			store_index = 0;
			first_seen = 1'b0;
			wait_cycles = 0;
			held_valid = 1'b0;
		end else begin
			if (held_valid) begin
				if (!mem_req_valid) begin
					$display("mem_req_valid dropped at %0t before the transfer", $time);
					abort_run();
				end
				check_req("stalled mem_req", mem_req, held_req);
			end
			held_valid = mem_req_valid && !mem_req_ready;
			held_req = mem_req;
			if (wait_cycles > 0) begin
				wait_cycles--;
				if (wait_cycles == 0) begin
					mem_rsp_valid <= 1'b1;
					mem_rsp.rdata <= read_word;
				end
			end
			if (mem_req_valid && mem_req_ready) begin
				serve_request(mem_req);
				wait_cycles = 1 + int'($urandom % 3);
			end
			mem_req_ready <= ($urandom % 4) != 0;
		end
	end

	initial begin
		int cycles;
		reset <= 1'b1;
		mem_req_ready <= 1'b0;
		mem_rsp_valid <= 1'b0;
		mem_rsp <= '0;
		void'($urandom(36));
		read_patterns();
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		cycles = 0;
		while (store_index < store_count) begin
			@(negedge clock);
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("timed out after %0d cycles with %0d of %0d stores seen",
					cycles, store_index, store_count);
				abort_run();
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period = 40
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever begin
			#(period / 2) clock = ~clock;
		end
	end

endmodule

//--- design/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top #(
	parameter int addr_width = 12
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              mem_req_ready,
	input  logic              mem_rsp_valid,
	input  cpu_pkg::mem_rsp_t mem_rsp,
	output logic              mem_req_valid,
	output cpu_pkg::mem_req_t mem_req
);
	import cpu_pkg::*;

	logic instr_valid;
	logic instr_ready;
	word_t instr;
	ctrl_t ctrl;
	logic alu_enable;
	logic mem_start;
	logic mem_done;
	logic reg_write_enable;
	logic [4:0] rt;
	logic [4:0] ra;
	logic [4:0] rb;
	logic [4:0] read_addr_b;
	logic [14:0] imm;
	word_t read_data_a;
	word_t read_data_b;
	word_t alu_result;
	word_t load_data;
	word_t write_data;
	logic fetch_req_valid;
	logic fetch_req_ready;
	logic fetch_rsp_valid;
	mem_req_t fetch_req;
	logic data_req_valid;
	logic data_req_ready;
	logic data_rsp_valid;
	mem_req_t data_req;

	// stores read their data register through port b
	assign read_addr_b = ctrl.is_store ? rt : rb;
	assign write_data = ctrl.is_load ? load_data : alu_result;

	cpu_controller cpu_controller_inst (
		.clock(clock), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.mem_done(mem_done), .instr_ready(instr_ready), .ctrl(ctrl),
		.alu_enable(alu_enable), .mem_start(mem_start),
		.reg_write_enable(reg_write_enable), .rt(rt), .ra(ra), .rb(rb), .imm(imm)
	);

	cpu_register_file cpu_register_file_inst (
		.clock(clock), .reset(reset), .read_addr_a(ra), .read_addr_b(read_addr_b),
		.write_enable(reg_write_enable), .write_addr(rt), .write_data(write_data),
		.read_data_a(read_data_a), .read_data_b(read_data_b)
	);

	cpu_alu cpu_alu_inst (
		.clock(clock), .reset(reset), .enable(alu_enable), .ctrl(ctrl),
		.operand_a(read_data_a), .operand_b(read_data_b), .imm(imm), .result(alu_result)
	);

	cpu_fetch_unit #(.addr_width(addr_width)) cpu_fetch_unit_inst (
		.clock(clock), .reset(reset), .req_ready(fetch_req_ready),
		.rsp_valid(fetch_rsp_valid), .rsp(mem_rsp), .instr_ready(instr_ready),
		.req_valid(fetch_req_valid), .req(fetch_req), .instr_valid(instr_valid),
		.instr(instr)
	);

	cpu_load_store_unit #(.addr_width(addr_width)) cpu_load_store_unit_inst (
		.clock(clock), .reset(reset), .start(mem_start), .is_store(ctrl.is_store),
		.base(read_data_a), .imm(imm), .store_data(read_data_b),
		.req_ready(data_req_ready), .rsp_valid(data_rsp_valid), .rsp(mem_rsp),
		.req_valid(data_req_valid), .req(data_req), .done(mem_done), .load_data(load_data)
	);

	cpu_bus_arbiter #(.addr_width(addr_width)) cpu_bus_arbiter_inst (
		.clock(clock), .reset(reset),
		.fetch_req_valid(fetch_req_valid), .fetch_req(fetch_req),
		.fetch_req_ready(fetch_req_ready), .fetch_rsp_valid(fetch_rsp_valid),
		.data_req_valid(data_req_valid), .data_req(data_req),
		.data_req_ready(data_req_ready), .data_rsp_valid(data_rsp_valid),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req),
		.mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid)
	);

endmodule

//--- design/cpu_bus_arbiter.sv
`timescale 1ns/1ps

module cpu_bus_arbiter #(
	parameter int addr_width = 12
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              fetch_req_valid,
	input  cpu_pkg::mem_req_t fetch_req,
	output logic              fetch_req_ready,
	output logic              fetch_rsp_valid,
	input  logic              data_req_valid,
	input  cpu_pkg::mem_req_t data_req,
	output logic              data_req_ready,
	output logic              data_rsp_valid,
	output logic              mem_req_valid,
	output cpu_pkg::mem_req_t mem_req,
	input  logic              mem_req_ready,
	input  logic              mem_rsp_valid
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {own_none, own_fetch, own_data} owner_t;

	owner_t owner;
	logic fetch_waiting;
	logic grant_data;
	logic grant_fetch;

	// a stalled fetch keeps the bus so the presented payload cannot switch
	assign grant_data = (owner == own_none) && data_req_valid && !fetch_waiting;
	assign grant_fetch = (owner == own_none) && fetch_req_valid && !grant_data;

	assign mem_req_valid = grant_data || grant_fetch;
	assign data_req_ready = grant_data && mem_req_ready;
	assign fetch_req_ready = grant_fetch && mem_req_ready;

	always_comb begin
		mem_req = grant_data ? data_req : fetch_req;
		mem_req.addr = '0;
		if (grant_data) begin
			mem_req.addr[addr_width-1:0] = data_req.addr[addr_width-1:0];
		end else begin
			mem_req.addr[addr_width-1:0] = fetch_req.addr[addr_width-1:0];
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			owner <= own_none;
			fetch_waiting <= 1'b0;
		end else begin
			fetch_waiting <= grant_fetch && !mem_req_ready;
			if (mem_req_valid && mem_req_ready) begin
				owner <= grant_data ? own_data : own_fetch;
			end else if (mem_rsp_valid) begin
				owner <= own_none;
			end
		end
	end

	assign fetch_rsp_valid = mem_rsp_valid && (owner == own_fetch);
	assign data_rsp_valid = mem_rsp_valid && (owner == own_data);

	a_rsp_has_owner: assert property (@(posedge clock) disable iff (reset)
		mem_rsp_valid |-> owner != own_none);

endmodule

//--- design/cpu_load_store_unit.sv
`timescale 1ns/1ps

module cpu_load_store_unit #(
	parameter int addr_width = 12
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              start,
	input  logic              is_store,
	input  cpu_pkg::word_t    base,
	input  logic [14:0]       imm,
	input  cpu_pkg::word_t    store_data,
	input  logic              req_ready,
	input  logic              rsp_valid,
	input  cpu_pkg::mem_rsp_t rsp,
	output logic              req_valid,
	output cpu_pkg::mem_req_t req,
	output logic              done,
	output cpu_pkg::word_t    load_data
);
	import cpu_pkg::*;

	word_t imm_sext;
	word_t sum;
	logic pending;

	assign imm_sext = {{17{imm[14]}}, imm};
	assign sum = base + imm_sext;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			req_valid <= 1'b0;
			pending <= 1'b0;
		end else if (start) begin
			req_valid <= 1'b1;
		end else if (req_valid && req_ready) begin
			req_valid <= 1'b0;
			pending <= 1'b1;
		end else if (rsp_valid) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			req.addr <= 30'(sum[addr_width-1:0]);
			req.write <= is_store;
			req.wdata <= store_data;
		end
		if (pending && rsp_valid) begin
			load_data <= rsp.rdata;
		end
	end

	// stores also get a response, so both end here
	assign done = pending && rsp_valid;

	a_req_stable: assert property (@(posedge clock) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

//--- design/cpu_fetch_unit.sv
`timescale 1ns/1ps

module cpu_fetch_unit #(
	parameter int addr_width = 12
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              req_ready,
	input  logic              rsp_valid,
	input  cpu_pkg::mem_rsp_t rsp,
	input  logic              instr_ready,
	output logic              req_valid,
	output cpu_pkg::mem_req_t req,
	output logic              instr_valid,
	output cpu_pkg::word_t    instr
);
	import cpu_pkg::*;

	logic [addr_width-1:0] pc;
	logic pending;
	logic buf_valid;
	word_t instr_buf;
	logic pop;

	assign pop = instr_valid && instr_ready;

	// prefetch once the buffer is free or being drained
	assign req_valid = !reset && !pending && (!buf_valid || pop);

	always_comb begin
		req = '0;
		req.addr = 30'(pc);
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			pending <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (req_valid && req_ready) begin
				pc <= pc + 1'b1;
				pending <= 1'b1;
			end else if (rsp_valid) begin
				pending <= 1'b0;
			end
			if (rsp_valid) begin
				buf_valid <= 1'b1;
			end else if (pop) begin
				buf_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			instr_buf <= rsp.rdata;
		end
	end

	assign instr_valid = buf_valid;
	assign instr = instr_buf;

	a_req_stable: assert property (@(posedge clock) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

//--- design/cpu_register_file.sv
`timescale 1ns/1ps

module cpu_register_file (
	input  logic            clock,
	input  logic            reset,
	input  logic [4:0]      read_addr_a,
	input  logic [4:0]      read_addr_b,
	input  logic            write_enable,
	input  logic [4:0]      write_addr,
	input  cpu_pkg::word_t  write_data,
	output cpu_pkg::word_t  read_data_a,
	output cpu_pkg::word_t  read_data_b
);
	import cpu_pkg::*;

	// r0 is an ordinary register here
	word_t regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	assign read_data_a = regs[read_addr_a];
	assign read_data_b = regs[read_addr_b];

endmodule

//--- design/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
	input  logic            clock,
	input  logic            reset,
	input  logic            enable,
	input  cpu_pkg::ctrl_t  ctrl,
	input  cpu_pkg::word_t  operand_a,
	input  cpu_pkg::word_t  operand_b,
	input  logic [14:0]     imm,
	output cpu_pkg::word_t  result
);
	import cpu_pkg::*;

	word_t imm_sext;
	word_t imm_value;
	word_t operand_b_sel;
	word_t next_result;
	logic [4:0] shamt;

	assign imm_sext = {{17{imm[14]}}, imm};

	always_comb begin
		case (ctrl.imm_kind)
			imm_zext:  imm_value = {17'b0, imm};
			imm_shamt: imm_value = {27'b0, imm[14:10]};
			default:   imm_value = imm_sext;
		endcase
	end

	assign operand_b_sel = ctrl.imm_select ? imm_value : operand_b;
	assign shamt = operand_b_sel[4:0];

	always_comb begin
		case (ctrl.alu_op)
			alu_add: next_result = operand_a + operand_b_sel;
			alu_sub: next_result = operand_a - operand_b_sel;
			alu_and: next_result = operand_a & operand_b_sel;
			alu_or:  next_result = operand_a | operand_b_sel;
			alu_xor: next_result = operand_a ^ operand_b_sel;
			alu_srl: next_result = operand_a >> shamt;
			alu_sll: next_result = operand_a << shamt;
			// rotate right through a doubled word
			default: next_result = 32'({operand_a, operand_a} >> shamt);
		endcase
		if (ctrl.move_select) begin
			next_result = imm_sext;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			result <= '0;
		end else if (enable) begin
			result <= next_result;
		end
	end

endmodule

//--- design/cpu_controller.sv
`timescale 1ns/1ps

module cpu_controller (
	input  logic            clock,
	input  logic            reset,
	input  logic            instr_valid,
	input  cpu_pkg::word_t  instr,
	input  logic            mem_done,
	output logic            instr_ready,
	output cpu_pkg::ctrl_t  ctrl,
	output logic            alu_enable,
	output logic            mem_start,
	output logic            reg_write_enable,
	output logic [4:0]      rt,
	output logic [4:0]      ra,
	output logic [4:0]      rb,
	output logic [14:0]     imm
);
	import cpu_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	word_t ir;
	logic is_mem;

	assign rt = ir[24:20];
	assign ra = ir[19:15];
	assign rb = ir[14:10];
	assign imm = ir[14:0];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
		end else begin
			state <= state_next;
		end
	end

	// instruction taken on the fetch handshake
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ir <= '0;
		end else if (instr_valid && instr_ready) begin
			ir <= instr;
		end
	end

	// unknown codes fall through as no-ops
	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		ctrl.imm_kind = imm_sext;
		case (opcode_t'(ir[30:25]))
			ty_base: begin
				ctrl.reg_write = 1'b1;
				case (sub_opcode_t'(ir[4:0]))
					op_add: ctrl.alu_op = alu_add;
					op_sub: ctrl.alu_op = alu_sub;
					op_and: ctrl.alu_op = alu_and;
					op_or:  ctrl.alu_op = alu_or;
					op_xor: ctrl.alu_op = alu_xor;
					op_srli: begin
						ctrl.alu_op = alu_srl;
						ctrl.imm_select = 1'b1;
						ctrl.imm_kind = imm_shamt;
					end
					op_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.imm_select = 1'b1;
						ctrl.imm_kind = imm_shamt;
					end
					op_rotri: begin
						ctrl.alu_op = alu_ror;
						ctrl.imm_select = 1'b1;
						ctrl.imm_kind = imm_shamt;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			addi: begin
				ctrl.imm_select = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			ori: begin
				ctrl.alu_op = alu_or;
				ctrl.imm_select = 1'b1;
				ctrl.imm_kind = imm_zext;
				ctrl.reg_write = 1'b1;
			end
			xori: begin
				ctrl.alu_op = alu_xor;
				ctrl.imm_select = 1'b1;
				ctrl.imm_kind = imm_zext;
				ctrl.reg_write = 1'b1;
			end
			movi: begin
				ctrl.move_select = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			lwi: begin
				ctrl.is_load = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			swi: ctrl.is_store = 1'b1;
			default: ctrl.reg_write = 1'b0;
		endcase
	end

	assign is_mem = ctrl.is_load || ctrl.is_store;

	always_comb begin
		state_next = state;
		case (state)
			st_fetch:     if (instr_valid) state_next = st_decode;
			st_decode:    state_next = st_execute;
			st_execute:   state_next = is_mem ? st_memory : st_writeback;
			st_memory:    if (mem_done) state_next = st_writeback;
			st_writeback: state_next = st_fetch;
			default:      state_next = st_fetch;
		endcase
	end

	assign instr_ready = (state == st_fetch);
	assign alu_enable = (state == st_execute);
	// single pulse that starts the load/store unit
	assign mem_start = (state == st_execute) && is_mem;
	assign reg_write_enable = (state == st_writeback) && ctrl.reg_write;

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;

	// major opcode in instr[30:25]
	typedef enum logic [5:0] {
		ty_base = 6'b100000,
		addi    = 6'b101000,
		ori     = 6'b101100,
		xori    = 6'b101011,
		movi    = 6'b100010,
		lwi     = 6'b000010,
		swi     = 6'b001010
	} opcode_t;

	// sub-opcode of ty_base in instr[4:0]
	typedef enum logic [4:0] {
		op_add   = 5'b00000,
		op_sub   = 5'b00001,
		op_and   = 5'b00010,
		op_xor   = 5'b00011,
		op_or    = 5'b00100,
		op_slli  = 5'b01000,
		op_srli  = 5'b01001,
		op_rotri = 5'b01011
	} sub_opcode_t;

	typedef enum logic [2:0] {
		st_fetch     = 3'd0,
		st_decode    = 3'd1,
		st_execute   = 3'd2,
		st_memory    = 3'd3,
		st_writeback = 3'd4
	} ctrl_state_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_srl, alu_sll, alu_ror
	} alu_op_t;

	// how the 15-bit immediate becomes a second operand
	typedef enum logic [1:0] {
		imm_zext  = 2'd0,
		imm_sext  = 2'd1,
		imm_shamt = 2'd2
	} imm_kind_t;

	typedef struct packed {
		logic [29:0] addr;
		logic        write;
		word_t       wdata;
	} mem_req_t;

	typedef struct packed {
		word_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		alu_op_t   alu_op;
		logic      imm_select;
		imm_kind_t imm_kind;
		logic      move_select;
		logic      is_load;
		logic      is_store;
		logic      reg_write;
	} ctrl_t;

endpackage
